// ==== Makefile ====
VERILATOR   ?= verilator
FILELIST    ?= sources.f
TOP         ?= tb_ray_box
RTL_TOP     ?= ray_box_top
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 1000
VFLAGS      ?= --timing --assert
FAIL_MSG    ?= Simulation failed
PASS_MSG    ?= Simulation passed

SRCS    := $(shell cat $(FILELIST))
RTL_SRC := $(filter rtl/%,$(SRCS))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRC)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "sim: failure reported in $(LOG)"; exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "sim: run ended without a verdict"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/delay_line.sv ====
`timescale 1ns/1ns

module delay_line #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 1
) (
	input  logic     clk,
	input  logic     rst,
	input  payload_t d,
	output payload_t q
);

	payload_t stages [DEPTH];   // stages[0] is the newest

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				stages[i] <= '0;
			end
		end else begin
			stages[0] <= d;
			for (int i = 1; i < DEPTH; i++) begin
				stages[i] <= stages[i-1]; // shift toward the tap
			end
		end
	end

	assign q = stages[DEPTH-1];

endmodule

// ==== rtl/fixed_point_pkg.sv ====
package fixed_point_pkg;

	////////////////////////////////////////////////////////////////////
	// widths of the signed fixed point formats
	////////////////////////////////////////////////////////////////////

	localparam int COORD_WIDTH = 16;                      // origin and box corners
	localparam int FRAC_BITS   = 8;                       // shared by coords and inv dirs
	localparam int INV_WIDTH   = 16;                      // inverse ray direction
	localparam int DIFF_WIDTH  = COORD_WIDTH + 1;         // corner minus origin, no overflow
	localparam int T_WIDTH     = DIFF_WIDTH + INV_WIDTH - FRAC_BITS; // product after rescale

	////////////////////////////////////////////////////////////////////
	// value types
	////////////////////////////////////////////////////////////////////

	typedef logic signed [COORD_WIDTH-1:0] coord_t;
	typedef logic signed [INV_WIDTH-1:0]   inv_dir_t;
	typedef logic signed [DIFF_WIDTH-1:0]  diff_t;
	typedef logic signed [T_WIDTH-1:0]     t_t;

	// unbounded interval of an axis running parallel to its slab
	localparam t_t T_POS_INF = {1'b0, {(T_WIDTH-1){1'b1}}};
	localparam t_t T_NEG_INF = {1'b1, {(T_WIDTH-1){1'b0}}};

endpackage

// ==== rtl/ray_box_top.sv ====
`timescale 1ns/1ns

module ray_box_top (
	input  logic                       clk,
	input  logic                       rst,
	input  fixed_point_pkg::coord_t    origin_x,
	input  fixed_point_pkg::coord_t    origin_y,
	input  fixed_point_pkg::coord_t    origin_z,
	input  fixed_point_pkg::coord_t    box_min_x,
	input  fixed_point_pkg::coord_t    box_min_y,
	input  fixed_point_pkg::coord_t    box_min_z,
	input  fixed_point_pkg::coord_t    box_max_x,
	input  fixed_point_pkg::coord_t    box_max_y,
	input  fixed_point_pkg::coord_t    box_max_z,
	input  fixed_point_pkg::inv_dir_t  inv_dir_x,
	input  fixed_point_pkg::inv_dir_t  inv_dir_y,
	input  fixed_point_pkg::inv_dir_t  inv_dir_z,
	input  logic                       parallel_x,
	input  logic                       parallel_y,
	input  logic                       parallel_z,
	output logic                       hit
);

	// per axis slab results, index 0 is x
	fixed_point_pkg::t_t t_min   [ray_pipe_pkg::AXIS_COUNT];
	fixed_point_pkg::t_t t_max   [ray_pipe_pkg::AXIS_COUNT];
	logic                outside [ray_pipe_pkg::AXIS_COUNT];

	////////////////////////////////////////////////////////////////////
	// one slab per axis
	////////////////////////////////////////////////////////////////////

	slab_axis u_axis_x (
		.clk      (clk),
		.rst      (rst),
		.origin   (origin_x),
		.box_min  (box_min_x),
		.box_max  (box_max_x),
		.inv_dir  (inv_dir_x),
		.parallel (parallel_x),
		.t_min    (t_min[0]),
		.t_max    (t_max[0]),
		.outside  (outside[0])
	);

	slab_axis u_axis_y (
		.clk      (clk),
		.rst      (rst),
		.origin   (origin_y),
		.box_min  (box_min_y),
		.box_max  (box_max_y),
		.inv_dir  (inv_dir_y),
		.parallel (parallel_y),
		.t_min    (t_min[1]),
		.t_max    (t_max[1]),
		.outside  (outside[1])
	);

	slab_axis u_axis_z (
		.clk      (clk),
		.rst      (rst),
		.origin   (origin_z),
		.box_min  (box_min_z),
		.box_max  (box_max_z),
		.inv_dir  (inv_dir_z),
		.parallel (parallel_z),
		.t_min    (t_min[2]),
		.t_max    (t_max[2]),
		.outside  (outside[2])
	);

	////////////////////////////////////////////////////////////////////
	// interval intersection and decision
	////////////////////////////////////////////////////////////////////

	slab_reduce u_reduce (
		.clk       (clk),
		.rst       (rst),
		.t_min_x   (t_min[0]),
		.t_min_y   (t_min[1]),
		.t_min_z   (t_min[2]),
		.t_max_x   (t_max[0]),
		.t_max_y   (t_max[1]),
		.t_max_z   (t_max[2]),
		.outside_x (outside[0]),
		.outside_y (outside[1]),
		.outside_z (outside[2]),
		.hit       (hit)
	);

endmodule

// ==== rtl/ray_pipe_pkg.sv ====
package ray_pipe_pkg;

	////////////////////////////////////////////////////////////////////
	// pipeline shape
	////////////////////////////////////////////////////////////////////

	localparam int AXIS_COUNT = 3;  // x, y, z

	// register stages per block
	localparam int SLAB_LATENCY   = 3; // difference, product, ordering
	localparam int REDUCE_LATENCY = 2; // near/far reduction, decision

	// inputs to hit
	localparam int TOTAL_LATENCY = SLAB_LATENCY + REDUCE_LATENCY;

endpackage

// ==== rtl/slab_axis.sv ====
`timescale 1ns/1ns

module slab_axis (
	input  logic                       clk,
	input  logic                       rst,
	input  fixed_point_pkg::coord_t    origin,
	input  fixed_point_pkg::coord_t    box_min,
	input  fixed_point_pkg::coord_t    box_max,
	input  fixed_point_pkg::inv_dir_t  inv_dir,
	input  logic                       parallel,
	output fixed_point_pkg::t_t        t_min,
	output fixed_point_pkg::t_t        t_max,
	output logic                       outside
);

	// stage 1
	fixed_point_pkg::diff_t    diff_min_q;
	fixed_point_pkg::diff_t    diff_max_q;
	logic                      inside_q1;

	// side inputs realigned to their stage
	fixed_point_pkg::inv_dir_t inv_dir_d;
	logic                      parallel_d;

	// stage 2
	logic signed [fixed_point_pkg::DIFF_WIDTH+fixed_point_pkg::INV_WIDTH-1:0] prod_min;
	logic signed [fixed_point_pkg::DIFF_WIDTH+fixed_point_pkg::INV_WIDTH-1:0] prod_max;
	fixed_point_pkg::t_t       t_lo_q;
	fixed_point_pkg::t_t       t_hi_q;
	logic                      inv_neg_q;
	logic                      inside_q2;

	////////////////////////////////////////////////////////////////////
	// delays for the inputs that skip the subtract stage
	////////////////////////////////////////////////////////////////////

	delay_line #(
		.payload_t (fixed_point_pkg::inv_dir_t),
		.DEPTH     (ray_pipe_pkg::SLAB_LATENCY - 2)
	) u_inv_dir_dly (
		.clk (clk),
		.rst (rst),
		.d   (inv_dir),
		.q   (inv_dir_d)   // meets the differences at the multiply
	);

	delay_line #(
		.payload_t (logic),
		.DEPTH     (ray_pipe_pkg::SLAB_LATENCY - 1)
	) u_parallel_dly (
		.clk (clk),
		.rst (rst),
		.d   (parallel),
		.q   (parallel_d)  // meets the products at the ordering
	);

	////////////////////////////////////////////////////////////////////
	// stage 1: corner minus origin
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			diff_min_q <= '0;
			diff_max_q <= '0;
			inside_q1  <= 1'b0;
		end else begin
			diff_min_q <= box_min - origin;   // sign extended to DIFF_WIDTH
			diff_max_q <= box_max - origin;
			inside_q1  <= (box_min <= origin) && (origin <= box_max);
		end
	end

	////////////////////////////////////////////////////////////////////
	// stage 2: scale by inverse direction
	////////////////////////////////////////////////////////////////////

	always_comb begin
		prod_min = diff_min_q * inv_dir_d;  // full width, exact
		prod_max = diff_max_q * inv_dir_d;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			t_lo_q    <= '0;
			t_hi_q    <= '0;
			inv_neg_q <= 1'b0;
			inside_q2 <= 1'b0;
		end else begin
			// dropping the low FRAC_BITS is the arithmetic shift
			t_lo_q    <= prod_min[$high(prod_min):fixed_point_pkg::FRAC_BITS];
			t_hi_q    <= prod_max[$high(prod_max):fixed_point_pkg::FRAC_BITS];
			inv_neg_q <= inv_dir_d[fixed_point_pkg::INV_WIDTH-1];
			inside_q2 <= inside_q1;
		end
	end

	////////////////////////////////////////////////////////////////////
	// stage 3: order by direction sign
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			t_min   <= '0;
			t_max   <= '0;
			outside <= 1'b0;
		end else if (parallel_d) begin
			t_min   <= fixed_point_pkg::T_NEG_INF; // axis never limits the interval
			t_max   <= fixed_point_pkg::T_POS_INF;
			outside <= ~inside_q2;                 // but may rule the ray out
		end else begin
			outside <= 1'b0;
			if (inv_neg_q) begin
				t_min <= t_hi_q;   // travelling toward min corner
				t_max <= t_lo_q;
			end else begin
				t_min <= t_lo_q;
				t_max <= t_hi_q;
			end
		end
	end

endmodule

// ==== rtl/slab_reduce.sv ====
`timescale 1ns/1ns

module slab_reduce (
	input  logic                 clk,
	input  logic                 rst,
	input  fixed_point_pkg::t_t  t_min_x,
	input  fixed_point_pkg::t_t  t_min_y,
	input  fixed_point_pkg::t_t  t_min_z,
	input  fixed_point_pkg::t_t  t_max_x,
	input  fixed_point_pkg::t_t  t_max_y,
	input  fixed_point_pkg::t_t  t_max_z,
	input  logic                 outside_x,
	input  logic                 outside_y,
	input  logic                 outside_z,
	output logic                 hit
);

	logic [ray_pipe_pkg::AXIS_COUNT-1:0] outside_vec;

	// comparator results
	logic ymin_gt;     // t_min_y >  t_min_x
	logic zmin_gt_y;   // t_min_z >  t_min_y
	logic xmin_gt_z;   // t_min_x >  t_min_z
	logic ymax_lt;     // t_max_y <  t_max_x
	logic zmax_lt_y;   // t_max_z <  t_max_y
	logic xmax_lt_z;   // t_max_x <  t_max_z

	fixed_point_pkg::t_t tnear;
	fixed_point_pkg::t_t tfar;

	// stage 4
	fixed_point_pkg::t_t tnear_q;
	fixed_point_pkg::t_t tfar_q;
	logic                any_outside_q;

	assign outside_vec = {outside_z, outside_y, outside_x};

	////////////////////////////////////////////////////////////////////
	// entry and exit selection
	////////////////////////////////////////////////////////////////////

	assign ymin_gt   = t_min_y > t_min_x;
	assign zmin_gt_y = t_min_z > t_min_y;
	assign xmin_gt_z = t_min_x > t_min_z;

	assign ymax_lt   = t_max_y < t_max_x;
	assign zmax_lt_y = t_max_z < t_max_y;
	assign xmax_lt_z = t_max_x < t_max_z;

	always_comb begin
		// latest entry
		if (ymin_gt) begin
			tnear = zmin_gt_y ? t_min_z : t_min_y;
		end else begin
			tnear = xmin_gt_z ? t_min_x : t_min_z; // x wins ties with y
		end

		// earliest exit
		if (ymax_lt) begin
			tfar = zmax_lt_y ? t_max_z : t_max_y;
		end else begin
			tfar = xmax_lt_z ? t_max_x : t_max_z;
		end
	end

	////////////////////////////////////////////////////////////////////
	// stage 4 and 5
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tnear_q       <= '0;
			tfar_q        <= '0;
			any_outside_q <= 1'b0;
		end else begin
			tnear_q       <= tnear;
			tfar_q        <= tfar;
			any_outside_q <= |outside_vec;  // parallel axis missed its slab
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hit <= 1'b0;
		end else begin
			hit <= ~any_outside_q && (tfar_q >= tnear_q) && (tfar_q > 0); // box not behind
		end
	end

endmodule

// ==== sources.f ====
rtl/fixed_point_pkg.sv
rtl/ray_pipe_pkg.sv
rtl/delay_line.sv
rtl/slab_axis.sv
rtl/slab_reduce.sv
rtl/ray_box_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/ray_box_assertions.sv
tests/tb_ray_box.sv

// ==== tests/ray_box_assertions.sv ====
`timescale 1ns/1ns

module ray_box_assertions (
	input logic                    clk,
	input logic                    rst,
	input fixed_point_pkg::coord_t box_min_x, box_min_y, box_min_z,
	input fixed_point_pkg::coord_t box_max_x, box_max_y, box_max_z,
	input fixed_point_pkg::t_t     t_min [ray_pipe_pkg::AXIS_COUNT],
	input fixed_point_pkg::t_t     t_max [ray_pipe_pkg::AXIS_COUNT],
	input logic                    hit
);

	int unsigned         failures = 0;
	fixed_point_pkg::t_t exit_min;   // earliest exit over the axes

	always_comb begin
		exit_min = t_max[0];
		for (int i = 1; i < ray_pipe_pkg::AXIS_COUNT; i++) begin
			exit_min = (t_max[i] < exit_min) ? t_max[i] : exit_min;
		end
	end

	////////////////////////////////////////////////////////////////////
	// slab intervals follow ordered boxes
	////////////////////////////////////////////////////////////////////

	x_ordered: assert property (@(posedge clk) disable iff (rst)
		$past(box_min_x <= box_max_x, ray_pipe_pkg::SLAB_LATENCY) |-> t_min[0] <= t_max[0])
	else begin
		failures++;
		$error("x slab interval reversed for an ordered box");
	end

	y_ordered: assert property (@(posedge clk) disable iff (rst)
		$past(box_min_y <= box_max_y, ray_pipe_pkg::SLAB_LATENCY) |-> t_min[1] <= t_max[1])
	else begin
		failures++;
		$error("y slab interval reversed for an ordered box");
	end

	z_ordered: assert property (@(posedge clk) disable iff (rst)
		$past(box_min_z <= box_max_z, ray_pipe_pkg::SLAB_LATENCY) |-> t_min[2] <= t_max[2])
	else begin
		failures++;
		$error("z slab interval reversed for an ordered box");
	end

	////////////////////////////////////////////////////////////////////
	// decision
	////////////////////////////////////////////////////////////////////

	// tfar register feeds hit, and itself came from the slab outputs
	hit_ahead: assert property (@(posedge clk) disable iff (rst)
		hit |-> $past(exit_min, 2) > fixed_point_pkg::t_t'(0))
	else begin
		failures++;
		$error("hit raised for a box behind the origin");
	end

	hit_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(hit))
	else begin
		failures++;
		$error("hit is unknown out of reset");
	end

endmodule

bind ray_box_top ray_box_assertions u_slab_checks (.*);

// ==== tests/tb_checker.sv ====
`timescale 1ns/1ns

module tb_checker (
	input logic                      clk,
	input logic                      rst,
	input fixed_point_pkg::coord_t   origin_x, origin_y, origin_z,
	input fixed_point_pkg::coord_t   box_min_x, box_min_y, box_min_z,
	input fixed_point_pkg::coord_t   box_max_x, box_max_y, box_max_z,
	input fixed_point_pkg::inv_dir_t inv_dir_x, inv_dir_y, inv_dir_z,
	input logic                      parallel_x, parallel_y, parallel_z,
	input logic                      hit
);

	int unsigned error_count = 0;
	int unsigned check_count = 0;
	int unsigned hit_count   = 0;
	int unsigned miss_count  = 0;

	bit expected_q [$];   // oldest ray first

	// narrows the ray interval by one slab, or flags a parallel miss
	function automatic void apply_axis(input longint origin, input longint box_min,
		input longint box_max, input longint inv, input bit parallel,
		inout longint tnear, inout longint tfar, inout bit outside);
		longint t_a;
		longint t_b;
		if (parallel) begin
			outside |= (origin < box_min) || (origin > box_max);
		end else begin
			t_a = ((box_min - origin) * inv) >>> fixed_point_pkg::FRAC_BITS; // floor
			t_b = ((box_max - origin) * inv) >>> fixed_point_pkg::FRAC_BITS;
			if (inv < 0) begin
				tnear = (t_b > tnear) ? t_b : tnear;   // enters through the max plane
				tfar  = (t_a < tfar) ? t_a : tfar;
			end else begin
				tnear = (t_a > tnear) ? t_a : tnear;
				tfar  = (t_b < tfar) ? t_b : tfar;
			end
		end
	endfunction

	function automatic bit expected_hit();
		longint tnear;
		longint tfar;
		bit     outside;
		tnear   = -(longint'(1) << 40);   // well past any slab distance
		tfar    = longint'(1) << 40;
		outside = 1'b0;
		apply_axis(origin_x, box_min_x, box_max_x, inv_dir_x, parallel_x, tnear, tfar, outside);
		apply_axis(origin_y, box_min_y, box_max_y, inv_dir_y, parallel_y, tnear, tfar, outside);
		apply_axis(origin_z, box_min_z, box_max_z, inv_dir_z, parallel_z, tnear, tfar, outside);
		return !outside && (tfar >= tnear) && (tfar > 0);
	endfunction

	always @(posedge clk) begin
		if (!rst) begin
			expected_q.push_back(expected_hit());
		end
	end

	// hit is settled half a cycle after the edge that updates it
	always @(negedge clk) begin
		bit want;
		if (!rst) begin
			want = 1'b0;   // reset contents still draining
			if (expected_q.size() >= ray_pipe_pkg::TOTAL_LATENCY) begin
				want = expected_q.pop_front();
				hit_count  += want;
				miss_count += !want;
			end
			check_count++;
			if (hit !== want) begin
				error_count++;
				$display("mismatch at %0t: hit expected %0b actual %0b", $time, want, hit);
			end
		end
	end

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;   // released after the last reset edge
	end

endmodule

// ==== tests/tb_ray_box.sv ====
`timescale 1ns/1ns

module tb_ray_box;

	localparam int NUM_VECTORS  = 2000;
	localparam int RESET_CYCLES = 4;
	localparam int PERIOD_NS    = 20;
	localparam int TIMEOUT_NS   =
		(2 * NUM_VECTORS + RESET_CYCLES + ray_pipe_pkg::TOTAL_LATENCY) * PERIOD_NS;

	logic                      clk;
	logic                      rst;
	fixed_point_pkg::coord_t   origin_x, origin_y, origin_z;
	fixed_point_pkg::coord_t   box_min_x, box_min_y, box_min_z;
	fixed_point_pkg::coord_t   box_max_x, box_max_y, box_max_z;
	fixed_point_pkg::inv_dir_t inv_dir_x, inv_dir_y, inv_dir_z;
	logic                      parallel_x, parallel_y, parallel_z;
	logic                      hit;
	int unsigned               coverage_errors;
	int unsigned               total_errors;

	tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock (.clk(clk), .rst(rst));

	ray_box_top DUT (.*);

	tb_checker u_checker (.*);

	// box around a random center, origin scattered near it (Q8.8)
	task automatic random_axis(output fixed_point_pkg::coord_t origin,
		output fixed_point_pkg::coord_t box_min, output fixed_point_pkg::coord_t box_max,
		output fixed_point_pkg::inv_dir_t inv_dir, output logic parallel);
		int center;
		int half;
		center  = int'($urandom_range(0, 8000)) - 4000;
		half    = int'($urandom_range(16, 1500));
		box_min = fixed_point_pkg::coord_t'(center - half);
		box_max = fixed_point_pkg::coord_t'(center + half);
		origin  = fixed_point_pkg::coord_t'(center + int'($urandom_range(0, 6000)) - 3000);
		inv_dir = fixed_point_pkg::inv_dir_t'(int'($urandom_range(0, 2048)) - 1024); // +-4.0
		if ($urandom_range(0, 15) == 0) begin
			inv_dir = '0;
		end
		parallel = ($urandom_range(0, 7) == 0);
	endtask

	initial begin : stimulus
		void'($urandom(32'h9d0c));
		{origin_x, origin_y, origin_z} = '0;
		{box_min_x, box_min_y, box_min_z} = '0;
		{box_max_x, box_max_y, box_max_z} = '0;
		{inv_dir_x, inv_dir_y, inv_dir_z} = '0;
		{parallel_x, parallel_y, parallel_z} = '0;
		coverage_errors = 0;
		@(negedge rst);
		repeat (NUM_VECTORS) begin
			@(negedge clk);
			random_axis(origin_x, box_min_x, box_max_x, inv_dir_x, parallel_x);
			random_axis(origin_y, box_min_y, box_max_y, inv_dir_y, parallel_y);
			random_axis(origin_z, box_min_z, box_max_z, inv_dir_z, parallel_z);
		end
		repeat (ray_pipe_pkg::TOTAL_LATENCY + 2) @(negedge clk);   // drain the pipeline
		#(PERIOD_NS / 4);   // clear of both clock edges
		if (u_checker.hit_count == 0 || u_checker.miss_count == 0) begin
			coverage_errors++;
			$display("the random rays did not produce both hits and misses");
		end
		total_errors = u_checker.error_count + DUT.u_slab_checks.failures + coverage_errors;
		$display("errors: %0d mismatches, %0d assertion failures, %0d other, %0d checks",
			u_checker.error_count, DUT.u_slab_checks.failures, coverage_errors,
			u_checker.check_count);
		if (total_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule
